//--- logic/fds_pkg.sv
// shared types, register map and constants for the FDS expansion block; every RTL file refers to it by scoped names
package fds_pkg;

	typedef logic [15:0] addr_t;  // cpu address
	typedef logic [7:0]  data_t;  // cpu data
	typedef logic [5:0]  sample_t;
	typedef logic [5:0]  gain_t;
	typedef logic [11:0] level_t;
	typedef logic [11:0] freq_t;
	typedef logic [23:0] phase_t;

	// one cpu access, qualified by ce at the modules
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  wr;
		logic  rd;
	} cpu_bus_t;

	// timer and irq
	localparam addr_t ADDR_TIMER_LO   = 16'h4020;
	localparam addr_t ADDR_TIMER_HI   = 16'h4021;
	localparam addr_t ADDR_TIMER_CTRL = 16'h4022;
	localparam addr_t ADDR_IO_EN      = 16'h4023;
	localparam addr_t ADDR_IRQ_STATUS = 16'h4030;

	// wave ram window, both ends inclusive
	localparam addr_t ADDR_WAVE_BASE = 16'h4040;
	localparam addr_t ADDR_WAVE_END  = 16'h407F;

	// audio control
	localparam addr_t ADDR_VOL_ENV   = 16'h4080;
	localparam addr_t ADDR_FREQ_LO   = 16'h4082;
	localparam addr_t ADDR_FREQ_HI   = 16'h4083;
	localparam addr_t ADDR_MASTER    = 16'h4089;
	localparam addr_t ADDR_ENV_SPEED = 16'h408A;

	// audio readback
	localparam addr_t ADDR_VOL_GAIN_RD = 16'h4090;
	localparam addr_t ADDR_PHASE_RD    = 16'h4091;
	localparam addr_t ADDR_SAMPLE_RD   = 16'h4096;

	localparam gain_t GAIN_MAX        = 6'd32;   // ramp ceiling and multiply cap
	localparam data_t ENV_SPEED_RESET = 8'hE8;
	localparam data_t OPEN_BUS        = 8'h40;   // unmapped read value
	localparam int    WAVE_CYCLES     = 16;      // ce strobes per phase step
	localparam int    PITCH_SHIFT     = 6;       // pitch = freq * 64 with no modulator

	// true when the address falls in the 64-entry wave ram window
	function automatic logic in_wave_window(addr_t addr);
		return (addr >= ADDR_WAVE_BASE) && (addr <= ADDR_WAVE_END);
	endfunction

endpackage

//--- logic/fds_timer_irq.sv
// programmable FDS timer: 16-bit latch and down-counter with one-shot or repeat irq, acked by a read of $4030
`timescale 1ns/1ps

module fds_timer_irq (
	input  logic             clk20,
	input  logic             reset,
	input  logic             ce,
	input  fds_pkg::cpu_bus_t bus,
	output logic             irq,
	output logic             io_enable
);

	logic [15:0] timer_latch;   // reload value
	logic [15:0] timer_count;
	logic        timer_repeat;
	logic        timer_en;
	logic        wr_strobe;
	logic        rd_strobe;
	logic        load_req;

	assign wr_strobe = ce && bus.wr;
	assign rd_strobe = ce && bus.rd;

	// $4022 bit1 only arms the timer while the io enable is set
	assign load_req = bus.wdata[1] && io_enable;

	// reload value bytes from $4020 and $4021
	always_ff @(posedge clk20) begin
		if (wr_strobe && bus.addr == fds_pkg::ADDR_TIMER_LO)
			timer_latch[7:0] <= bus.wdata;
		if (wr_strobe && bus.addr == fds_pkg::ADDR_TIMER_HI)
			timer_latch[15:8] <= bus.wdata;
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			timer_count  <= '0;
			timer_repeat <= 1'b0;
			timer_en     <= 1'b0;
			io_enable    <= 1'b0;
			irq          <= 1'b0;
		end else begin
			// countdown, one step per cpu cycle
			if (ce && timer_en) begin
				if (timer_count == 16'd0) begin
					irq         <= 1'b1;
					timer_count <= timer_latch;
					if (!timer_repeat)
						timer_en <= 1'b0;  // one-shot stops here
				end else begin
					timer_count <= timer_count - 16'd1;
				end
			end

			// register writes take priority over the tick
			if (wr_strobe) begin
				case (bus.addr)
					fds_pkg::ADDR_TIMER_CTRL: begin
						timer_repeat <= bus.wdata[0];
						timer_en     <= load_req;
						if (load_req)
							timer_count <= timer_latch;
						else
							irq <= 1'b0;
					end
					fds_pkg::ADDR_IO_EN: begin
						io_enable <= bus.wdata[0];
						if (!bus.wdata[0]) begin
							timer_en <= 1'b0;
							irq      <= 1'b0;
						end
					end
					default: ;
				endcase
			end

			// status read acknowledges, wins over a same-cycle fire
			if (rd_strobe && bus.addr == fds_pkg::ADDR_IRQ_STATUS)
				irq <= 1'b0;
		end
	end

endmodule

//--- logic/fds_vol_envelope.sv
// FDS volume envelope: gain register written at $4080, ticked by the $408A speed and ramped up or down
`timescale 1ns/1ps

module fds_vol_envelope (
	input  logic              clk20,
	input  logic              reset,
	input  logic              ce,
	input  fds_pkg::cpu_bus_t bus,
	input  logic              wave_halt,
	output fds_pkg::gain_t    gain
);

	logic [5:0]     vol_speed;     // periods per gain step, minus one
	logic           vol_dir;       // 1 = increase
	logic           vol_disable;
	logic           env_disable;   // global envelope stop from $4083 bit6
	fds_pkg::data_t env_speed;
	logic [11:0]    env_ticks;
	logic [5:0]     vol_ticks;
	logic [11:0]    tick_limit;
	logic [11:0]    tick_step;
	logic           env_run;
	logic           wr_strobe;

	assign wr_strobe  = ce && bus.wr;
	assign tick_limit = {1'b0, env_speed, 3'b111};     // speed * 8 + 7
	assign tick_step  = wave_halt ? 12'd4 : 12'd1;     // halted wave runs the envelope 4x
	assign env_run    = !env_disable && (env_speed != 8'd0) && !vol_disable;

	always_ff @(posedge clk20) begin
		if (reset) begin
			vol_speed   <= '0;
			vol_dir     <= 1'b0;
			vol_disable <= 1'b1;
			env_disable <= 1'b1;
			env_speed   <= fds_pkg::ENV_SPEED_RESET;
			env_ticks   <= '0;
			vol_ticks   <= '0;
			gain        <= '0;
		end else if (ce) begin
			if (env_run) begin
				if (env_ticks >= tick_limit) begin
					env_ticks <= '0;
					if (vol_ticks == vol_speed) begin
						vol_ticks <= '0;
						if (vol_dir && gain < fds_pkg::GAIN_MAX)
							gain <= gain + 6'd1;
						else if (!vol_dir && gain != 6'd0)
							gain <= gain - 6'd1;
					end else begin
						vol_ticks <= vol_ticks + 6'd1;
					end
				end else begin
					env_ticks <= env_ticks + tick_step;
				end
			end

			if (wr_strobe) begin
				case (bus.addr)
					fds_pkg::ADDR_VOL_ENV: begin
						{vol_disable, vol_dir, vol_speed} <= bus.wdata;
						if (bus.wdata[7])
							gain <= bus.wdata[5:0];  // direct gain load
						env_ticks <= '0;
						vol_ticks <= '0;
					end
					fds_pkg::ADDR_FREQ_HI: begin
						env_disable <= bus.wdata[6];
						if (bus.wdata[6]) begin
							env_ticks <= '0;
							vol_ticks <= '0;
						end
					end
					fds_pkg::ADDR_ENV_SPEED: begin
						env_speed <= bus.wdata;
						env_ticks <= '0;
						vol_ticks <= '0;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- logic/fds_wave_channel.sv
// FDS wavetable channel: 64 x 6-bit wave ram, phase accumulator, output latches and master-volume scaling
`timescale 1ns/1ps

module fds_wave_channel (
	input  logic              clk20,
	input  logic              reset,
	input  logic              ce,
	input  fds_pkg::cpu_bus_t bus,
	input  fds_pkg::gain_t    gain,
	output logic              wave_halt,
	output fds_pkg::data_t    phase_rd,
	output fds_pkg::data_t    sample_rd,
	output fds_pkg::data_t    wave_rd,
	output fds_pkg::level_t   audio_level
);

	localparam int CYCLE_W = $clog2(fds_pkg::WAVE_CYCLES);

	fds_pkg::sample_t wave_ram [64];
	fds_pkg::freq_t   wave_freq;
	fds_pkg::phase_t  wave_accum;
	fds_pkg::phase_t  wave_pitch;
	fds_pkg::sample_t sample_latch;
	fds_pkg::gain_t   gain_latch;
	fds_pkg::gain_t   gain_capped;
	fds_pkg::sample_t cur_sample;
	logic [CYCLE_W-1:0] cycles;
	logic [5:0]       wave_idx;
	logic [1:0]       master_vol;
	logic             wave_wren;     // cpu owns the ram, output latch frozen
	logic             wr_strobe;
	logic             ram_we;
	fds_pkg::level_t  mul_out;
	logic [12:0]      mul_x2;

	assign wr_strobe  = ce && bus.wr;
	assign ram_we     = wr_strobe && wave_wren && fds_pkg::in_wave_window(bus.addr);
	assign wave_idx   = wave_accum[23:18];   // top six bits pick the sample
	assign cur_sample = wave_ram[wave_idx];
	assign wave_pitch = fds_pkg::phase_t'(wave_freq) << fds_pkg::PITCH_SHIFT;

	// readback
	assign phase_rd  = wave_accum[19:12];
	assign sample_rd = {2'b01, cur_sample};
	assign wave_rd   = wave_wren ? {2'b00, wave_ram[bus.addr[5:0]]} : {2'b00, cur_sample};

	always_ff @(posedge clk20) begin
		if (ram_we)
			wave_ram[bus.addr[5:0]] <= bus.wdata[5:0];
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			wave_freq    <= '0;
			wave_halt    <= 1'b1;
			wave_wren    <= 1'b0;
			master_vol   <= 2'd0;
			wave_accum   <= '0;
			cycles       <= '0;
			sample_latch <= '0;
			gain_latch   <= '0;
		end else if (ce) begin
			cycles <= wave_halt ? '0 : cycles + 1'b1;
			if (!wave_halt && cycles == CYCLE_W'(fds_pkg::WAVE_CYCLES - 1))
				wave_accum <= wave_accum + wave_pitch;

			// gain follows only at the start of a wave period
			if (wave_idx == 6'd0)
				gain_latch <= gain;
			if (!wave_wren)
				sample_latch <= cur_sample;

			if (bus.wr) begin
				case (bus.addr)
					fds_pkg::ADDR_FREQ_LO: wave_freq[7:0] <= bus.wdata;
					fds_pkg::ADDR_FREQ_HI: begin
						wave_freq[11:8] <= bus.wdata[3:0];
						wave_halt       <= bus.wdata[7];
						if (bus.wdata[7]) begin
							wave_accum <= '0;  // restart from sample 0
							cycles     <= '0;
						end
					end
					fds_pkg::ADDR_MASTER: begin
						wave_wren  <= bus.wdata[7];
						master_vol <= bus.wdata[1:0];
					end
					default: ;
				endcase
			end
		end
	end

	// volume math
	assign gain_capped = (gain_latch > fds_pkg::GAIN_MAX) ? fds_pkg::GAIN_MAX : gain_latch;
	assign mul_out     = fds_pkg::level_t'(sample_latch) * fds_pkg::level_t'(gain_capped);
	assign mul_x2      = {mul_out, 1'b0};

	always_comb begin
		case (master_vol)
			2'd0:    audio_level = mul_out;
			2'd1:    audio_level = fds_pkg::level_t'(mul_x2 / 13'd3);  // 2/3
			2'd2:    audio_level = {1'b0, mul_out[11:1]};             // 1/2
			default: audio_level = fds_pkg::level_t'(mul_x2 / 13'd5);  // 2/5
		endcase
	end

endmodule

//--- logic/fds_expansion.sv
// top of the FDS expansion peripheral: timer irq, volume envelope and wave channel behind one cpu read mux
`timescale 1ns/1ps

module fds_expansion (
	input  logic              clk20,
	input  logic              reset,
	input  logic              ce,          // one strobe per cpu cycle
	input  fds_pkg::cpu_bus_t bus,
	output fds_pkg::data_t    read_data,
	output logic              irq,
	output fds_pkg::level_t   audio_level
);

	fds_pkg::gain_t gain;
	fds_pkg::data_t phase_rd;
	fds_pkg::data_t sample_rd;
	fds_pkg::data_t wave_rd;
	logic           wave_halt;
	logic           io_enable;   // $4023 bit0, observed by the properties

	fds_timer_irq u_timer (
		.clk20     (clk20),
		.reset     (reset),
		.ce        (ce),
		.bus       (bus),
		.irq       (irq),
		.io_enable (io_enable)
	);

	fds_vol_envelope u_env (
		.clk20     (clk20),
		.reset     (reset),
		.ce        (ce),
		.bus       (bus),
		.wave_halt (wave_halt),
		.gain      (gain)
	);

	fds_wave_channel u_wave (
		.clk20       (clk20),
		.reset       (reset),
		.ce          (ce),
		.bus         (bus),
		.gain        (gain),
		.wave_halt   (wave_halt),
		.phase_rd    (phase_rd),
		.sample_rd   (sample_rd),
		.wave_rd     (wave_rd),
		.audio_level (audio_level)
	);

	// read mux, same cycle as the address
	always_comb begin
		if (bus.addr == fds_pkg::ADDR_IRQ_STATUS) begin
			read_data = {7'd0, irq};
		end else if (fds_pkg::in_wave_window(bus.addr)) begin
			read_data = wave_rd;
		end else begin
			case (bus.addr)
				fds_pkg::ADDR_VOL_GAIN_RD: read_data = {2'b01, gain};
				fds_pkg::ADDR_PHASE_RD:    read_data = phase_rd;
				fds_pkg::ADDR_SAMPLE_RD:   read_data = sample_rd;
				default:                   read_data = fds_pkg::OPEN_BUS;
			endcase
		end
	end

endmodule

//--- verif/fds_expansion_properties.sv
// concurrent checks on the FDS expansion top level, attached to every instance through bind
`timescale 1ns/1ps

module fds_expansion_properties (
	input logic            clk20,
	input logic            reset,
	input logic            ce,
	input logic            irq,
	input logic            io_enable,
	input fds_pkg::level_t audio_level
);

	localparam int LEVEL_MAX = 63 * 32;   // full sample at capped gain

	// reset clears the flag at once
	irq_low_after_reset: assert property (@(posedge clk20) reset |=> !irq)
		else $error("irq high in the cycle after reset");

	irq_rise_on_ce: assert property (@(posedge clk20) disable iff (reset)
		$rose(irq) |-> $past(ce))
		else $error("irq rose on a clock without ce");

	// timer only fires while the io enable is on
	irq_needs_io_enable: assert property (@(posedge clk20) disable iff (reset)
		$rose(irq) |-> $past(io_enable))
		else $error("irq rose while the io enable was off");

	// master volume only ever scales down
	audio_level_range: assert property (@(posedge clk20) disable iff (reset)
		audio_level <= fds_pkg::level_t'(LEVEL_MAX))
		else $error("audio_level above the 63 x 32 ceiling");

endmodule

bind fds_expansion fds_expansion_properties u_props (
	.clk20       (clk20),
	.reset       (reset),
	.ce          (ce),
	.irq         (irq),
	.io_enable   (io_enable),
	.audio_level (audio_level)
);

//--- verif/fds_expansion_tb.sv
// testbench for the FDS expansion block: drives cpu accesses on ce strobes, checks irq, readback and audio
`timescale 1ns/1ps

module fds_expansion_tb;

	localparam int SEED         = 79;
	localparam int RESET_CYCLES = 10;
	// test lengths in ce strobes
	localparam int TIMER_LEN = 120;
	localparam int GATE_LEN  = 400;
	localparam int WAVE_LEN  = 160;
	localparam int LEVEL_LEN = 100;
	localparam int ENV_LEN   = 460;
	localparam int RUN_LEN   = 80;
	localparam int WATCHDOG_CYCLES =
		(TIMER_LEN + GATE_LEN + WAVE_LEN + LEVEL_LEN + ENV_LEN + RUN_LEN) * 4 * 2 + RESET_CYCLES;

	logic              clk20;
	logic              reset;
	logic              ce;
	fds_pkg::cpu_bus_t bus;
	fds_pkg::data_t    read_data;
	logic              irq;
	fds_pkg::level_t   audio_level;

	integer           seed;
	fds_pkg::sample_t wave_copy [64];
	fds_pkg::level_t  exp_level;
	logic             level_armed;   // compare process active
	int               level_checks;

	fds_expansion u_fds_expansion (
		.clk20       (clk20),
		.reset       (reset),
		.ce          (ce),
		.bus         (bus),
		.read_data   (read_data),
		.irq         (irq),
		.audio_level (audio_level)
	);

	always #4 clk20 = ~clk20;   // 8 ns period

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// one ce strobe, then three quiet cycles; returns at a falling edge
	task automatic cpu_cycle(input logic wr, input logic rd, input fds_pkg::addr_t a,
		input fds_pkg::data_t d, output fds_pkg::data_t rd_value);
		@(posedge clk20);
		#1;
		ce        = 1'b1;
		bus.addr  = a;
		bus.wdata = d;
		bus.wr    = wr;
		bus.rd    = rd;
		@(negedge clk20);
		rd_value = read_data;   // combinational, before the acting edge
		@(posedge clk20);
		#1;
		ce  = 1'b0;
		bus = '0;
		repeat (2) @(posedge clk20);
		@(negedge clk20);
	endtask

	task automatic bus_write(input fds_pkg::addr_t a, input fds_pkg::data_t d);
		fds_pkg::data_t dummy;
		cpu_cycle(1'b1, 1'b0, a, d, dummy);
	endtask

	task automatic bus_read(input fds_pkg::addr_t a, output fds_pkg::data_t v);
		cpu_cycle(1'b0, 1'b1, a, 8'h00, v);
	endtask

	task automatic idle_ce(input int n);
		fds_pkg::data_t dummy;
		repeat (n) cpu_cycle(1'b0, 1'b0, 16'h0000, 8'h00, dummy);
	endtask

	// sample times capped gain, then the master volume fraction
	function automatic fds_pkg::level_t expected_level(input int sample, input int gain,
		input int master);
		int cap;
		int p;
		cap = (gain > 32) ? 32 : gain;
		p   = sample * cap;
		case (master)
			0:       return fds_pkg::level_t'(p);
			1:       return fds_pkg::level_t'((p * 2) / 3);
			2:       return fds_pkg::level_t'(p / 2);
			default: return fds_pkg::level_t'((p * 2) / 5);
		endcase
	endfunction

	always @(negedge clk20) begin
		if (level_armed) begin
			check_value("audio_level", exp_level, audio_level);
			level_checks++;
		end
	end

	task automatic timer_test();
		int n;
		int k;
		fds_pkg::data_t v;
		n = 2 + ($random(seed) & 31);
		bus_write(fds_pkg::ADDR_IO_EN, 8'h01);
		bus_write(fds_pkg::ADDR_TIMER_LO, n[7:0]);
		bus_write(fds_pkg::ADDR_TIMER_HI, 8'h00);
		bus_write(fds_pkg::ADDR_TIMER_CTRL, 8'h02);   // one-shot
		for (k = 1; k <= n + 1; k++) begin
			idle_ce(1);
			check_value("timer_irq_edge", (k == n + 1), irq);
		end
		idle_ce(4);
		check_value("timer_irq_held", 1, irq);
		bus_read(fds_pkg::ADDR_IRQ_STATUS, v);
		check_value("timer_status_read", 8'h01, v);
		check_value("timer_irq_ack", 0, irq);
		for (k = 0; k < n + 4; k++) begin
			idle_ce(1);
			check_value("timer_one_shot_quiet", 0, irq);
		end
	endtask

	task automatic gate_test();
		int n;
		int k;
		fds_pkg::data_t v;
		n = 2 + ($random(seed) & 15);
		bus_write(fds_pkg::ADDR_IO_EN, 8'h00);
		bus_write(fds_pkg::ADDR_TIMER_CTRL, 8'h03);
		for (k = 0; k < 300; k++) begin
			idle_ce(1);
			check_value("gate_irq_blocked", 0, irq);
		end
		bus_write(fds_pkg::ADDR_TIMER_LO, n[7:0]);
		bus_write(fds_pkg::ADDR_TIMER_HI, 8'h00);
		bus_write(fds_pkg::ADDR_IO_EN, 8'h01);
		bus_write(fds_pkg::ADDR_TIMER_CTRL, 8'h03);   // repeat
		idle_ce(n);
		check_value("repeat_irq_early", 0, irq);
		idle_ce(1);
		check_value("repeat_irq_first", 1, irq);
		bus_read(fds_pkg::ADDR_IRQ_STATUS, v);   // ack is the first ce of the next period
		check_value("repeat_irq_ack", 0, irq);
		for (k = 2; k <= n + 1; k++) begin
			idle_ce(1);
			check_value("repeat_irq_refire", (k == n + 1), irq);
		end
		bus_write(fds_pkg::ADDR_IO_EN, 8'h00);
		check_value("gate_disable_clears", 0, irq);
	endtask

	task automatic wave_ram_test();
		int k;
		fds_pkg::data_t v;
		bus_write(fds_pkg::ADDR_MASTER, 8'h80);   // cpu owns the ram
		for (k = 0; k < 64; k++) begin
			wave_copy[k] = $random(seed);
			bus_write(fds_pkg::addr_t'(16'h4040 + k), {2'b00, wave_copy[k]});
		end
		for (k = 0; k < 64; k++) begin
			bus_read(fds_pkg::addr_t'(16'h4040 + k), v);
			check_value("wave_ram_readback", {2'b00, wave_copy[k]}, v);
		end
		bus_read(16'h4000, v);
		check_value("open_bus_4000", 8'h40, v);
		bus_read(16'h4024, v);
		check_value("open_bus_4024", 8'h40, v);
		bus_read(16'h4085, v);
		check_value("open_bus_4085", 8'h40, v);
		bus_read(16'h4100, v);
		check_value("open_bus_4100", 8'h40, v);
	endtask

	task automatic level_case(input int s, input int g, input int m);
		fds_pkg::data_t v;
		bus_write(fds_pkg::ADDR_VOL_ENV, {2'b10, g[5:0]});   // direct gain load
		bus_write(fds_pkg::ADDR_MASTER, 8'h80);
		bus_write(fds_pkg::ADDR_WAVE_BASE, {2'b00, s[5:0]});
		bus_write(fds_pkg::ADDR_MASTER, m[7:0]);
		idle_ce(2);
		exp_level   = expected_level(s, g, m);
		level_armed = 1'b1;
		idle_ce(1);
		level_armed = 1'b0;
		bus_read(fds_pkg::ADDR_VOL_GAIN_RD, v);
		check_value("gain_readback", {2'b01, g[5:0]}, v);
		bus_read(fds_pkg::ADDR_SAMPLE_RD, v);
		check_value("sample_readback", {2'b01, s[5:0]}, v);
	endtask

	task automatic level_test();
		int r;
		int m;
		bus_write(fds_pkg::ADDR_FREQ_HI, 8'hC0);   // halted, envelope stopped
		for (r = 0; r < 2; r++) begin
			for (m = 0; m < 4; m++) begin
				if (r == 0)
					level_case(63, 63 - m, m);   // near the top of the range
				else
					level_case($random(seed) & 63, $random(seed) & 63, m);
			end
		end
	endtask

	task automatic envelope_test();
		int k;
		int prev;
		fds_pkg::data_t v;
		bus_write(fds_pkg::ADDR_VOL_ENV, 8'h80);    // gain 0
		bus_write(fds_pkg::ADDR_VOL_ENV, 8'h40);    // increase
		bus_write(fds_pkg::ADDR_ENV_SPEED, 8'h01);
		bus_write(fds_pkg::ADDR_FREQ_HI, 8'h80);
		prev = 0;
		for (k = 0; k < 200 && prev != 32; k++) begin
			bus_read(fds_pkg::ADDR_VOL_GAIN_RD, v);
			check_value("env_read_prefix", 2'b01, v[7:6]);
			check_value("env_rise_monotonic", 1, v[5:0] >= prev);
			prev = v[5:0];
		end
		check_value("env_rise_top", 32, prev);
		for (k = 0; k < 20; k++) begin
			bus_read(fds_pkg::ADDR_VOL_GAIN_RD, v);
			check_value("env_rise_hold", 32, v[5:0]);
		end
		bus_write(fds_pkg::ADDR_VOL_ENV, 8'h00);    // decrease
		for (k = 0; k < 200 && prev != 0; k++) begin
			bus_read(fds_pkg::ADDR_VOL_GAIN_RD, v);
			check_value("env_fall_monotonic", 1, v[5:0] <= prev);
			prev = v[5:0];
		end
		check_value("env_fall_bottom", 0, prev);
		for (k = 0; k < 20; k++) begin
			bus_read(fds_pkg::ADDR_VOL_GAIN_RD, v);
			check_value("env_fall_hold", 0, v[5:0]);
		end
		bus_write(fds_pkg::ADDR_FREQ_HI, 8'hC0);
	endtask

	task automatic running_wave_test();
		int k;
		logic moved;
		fds_pkg::data_t v;
		bus_write(fds_pkg::ADDR_FREQ_LO, 8'h00);
		bus_write(fds_pkg::ADDR_FREQ_HI, 8'h01);   // run at frequency $100
		moved = 1'b0;
		for (k = 0; k < 64 && !moved; k++) begin
			bus_read(fds_pkg::ADDR_PHASE_RD, v);
			moved = (v != 8'h00);
		end
		check_value("wave_phase_moves", 1, moved);
	endtask

	initial begin
		seed         = SEED;
		clk20        = 1'b0;
		reset        = 1'b1;
		ce           = 1'b0;
		bus          = '0;
		exp_level    = '0;
		level_armed  = 1'b0;
		level_checks = 0;
		repeat (RESET_CYCLES) @(posedge clk20);
		#1;
		reset = 1'b0;
		timer_test();
		gate_test();
		wave_ram_test();
		level_test();
		envelope_test();
		running_wave_test();
		if (level_checks == 0) begin
			$display("the audio level compare process never ran");
			$display("Test FAILED");
			$fatal(1);
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk20);
		$display("watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$fatal(1);
	end

endmodule

//--- flist.f
logic/fds_pkg.sv
logic/fds_timer_irq.sv
logic/fds_vol_envelope.sv
logic/fds_wave_channel.sv
logic/fds_expansion.sv
verif/fds_expansion_properties.sv
verif/fds_expansion_tb.sv
